//--- exu_pkg.sv
package exu_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    // Architectural register count
    localparam int num_regs = 32;

    // Result stages after EX (DM1, DM2, DM3, WB)
    localparam int result_stages = 4;

    // Register index, fixed by the ISA
    typedef logic [4:0] reg_addr_t;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sll  = 4'd6,
        alu_srl  = 4'd7,
        alu_addi = 4'd8
    } alu_op_t;

    // Where an EX operand came from
    typedef enum logic [2:0] {
        fwd_none = 3'd0,
        fwd_dm1  = 3'd1,
        fwd_dm2  = 3'd2,
        fwd_dm3  = 3'd3,
        fwd_wb   = 3'd4
    } fwd_src_t;

endpackage

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file import exu_pkg::*; #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  reg_addr_t             rs1_addr,
    input  reg_addr_t             rs2_addr,
    input  logic                  wr_en,
    input  reg_addr_t             wr_addr,
    input  logic [data_width-1:0] wr_data,
    output logic [data_width-1:0] rs1_data,
    output logic [data_width-1:0] rs2_data
);

    logic [data_width-1:0] regs [num_regs];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < num_regs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && (wr_addr != '0))
        begin
            // x0 never takes a write
            regs[wr_addr] <= wr_data;
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    // No write-through here, WB forwarding covers the same-cycle case
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit import exu_pkg::*; #(
    parameter int data_width = 32
) (
    input  reg_addr_t             rs1_addr,
    input  reg_addr_t             rs2_addr,
    input  logic [data_width-1:0] rf_rs1_data,
    input  logic [data_width-1:0] rf_rs2_data,
    input  logic                  dm1_valid,
    input  reg_addr_t             dm1_rd,
    input  logic [data_width-1:0] dm1_data,
    input  logic                  dm2_valid,
    input  reg_addr_t             dm2_rd,
    input  logic [data_width-1:0] dm2_data,
    input  logic                  dm3_valid,
    input  reg_addr_t             dm3_rd,
    input  logic [data_width-1:0] dm3_data,
    input  logic                  wb_valid,
    input  reg_addr_t             wb_rd,
    input  logic [data_width-1:0] wb_data,
    output logic [data_width-1:0] rs1_data,
    output logic [data_width-1:0] rs2_data,
    output fwd_src_t              rs1_src,
    output fwd_src_t              rs2_src
);

    // Youngest valid producer wins, x0 is never forwarded
    function automatic fwd_src_t pick_src(input reg_addr_t addr);
        fwd_src_t src;
        src = fwd_none;
        if (addr != '0)
        begin
            if (dm1_valid && (dm1_rd == addr))
                src = fwd_dm1;
            else if (dm2_valid && (dm2_rd == addr))
                src = fwd_dm2;
            else if (dm3_valid && (dm3_rd == addr))
                src = fwd_dm3;
            else if (wb_valid && (wb_rd == addr))
                src = fwd_wb;
        end
        return src;
    endfunction

    // Operand mux, register file when nothing matched
    function automatic logic [data_width-1:0] pick_data(input fwd_src_t src,
                                                        input logic [data_width-1:0] rf_data);
        logic [data_width-1:0] data;
        case (src)
            fwd_dm1: data = dm1_data;
            fwd_dm2: data = dm2_data;
            fwd_dm3: data = dm3_data;
            fwd_wb:  data = wb_data;
            default: data = rf_data;
        endcase
        return data;
    endfunction

    always_comb
    begin
        rs1_src  = pick_src(rs1_addr);
        rs2_src  = pick_src(rs2_addr);
        rs1_data = pick_data(rs1_src, rf_rs1_data);
        rs2_data = pick_data(rs2_src, rf_rs2_data);
    end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu import exu_pkg::*; #(
    parameter int data_width = 32
) (
    input  alu_op_t               op,
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    input  logic [data_width-1:0] imm,
    output logic [data_width-1:0] result
);

    logic [4:0] shamt;
    logic       less;

    // Shift amount from the low bits of b
    assign shamt = b[4:0];
    assign less  = ($signed(a) < $signed(b));

    //////////////////////////////
    // Operation select
    //////////////////////////////

    always_comb
    begin
        case (op)
            alu_add:
                result = a + b;
            alu_sub:
                result = a - b;
            alu_and:
                result = a & b;
            alu_or:
                result = a | b;
            alu_xor:
                result = a ^ b;
            alu_slt:
            begin
                result    = '0;
                result[0] = less;
            end
            alu_sll:
                result = a << shamt;
            alu_srl:
                result = a >> shamt;
            alu_addi:
                result = a + imm;    // immediate replaces rs2
            default:
                result = '0;
        endcase
    end

endmodule

//--- result_pipe.sv
`timescale 1ns/1ps

module result_pipe import exu_pkg::*; #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    input  alu_op_t               issue_op,
    input  reg_addr_t             issue_rs1,
    input  reg_addr_t             issue_rs2,
    input  reg_addr_t             issue_rd,
    input  logic [data_width-1:0] issue_imm,
    input  logic [data_width-1:0] alu_result,
    output logic                  ex_valid,
    output alu_op_t               ex_op,
    output reg_addr_t             ex_rs1,
    output reg_addr_t             ex_rs2,
    output reg_addr_t             ex_rd,
    output logic [data_width-1:0] ex_imm,
    output logic                  dm1_valid,
    output reg_addr_t             dm1_rd,
    output logic [data_width-1:0] dm1_data,
    output logic                  dm2_valid,
    output reg_addr_t             dm2_rd,
    output logic [data_width-1:0] dm2_data,
    output logic                  dm3_valid,
    output reg_addr_t             dm3_rd,
    output logic [data_width-1:0] dm3_data,
    output logic                  wb_valid,
    output reg_addr_t             wb_rd,
    output logic [data_width-1:0] wb_data
);

    // Index 0 is DM1 and the last index is WB
    logic                  stage_valid [result_stages];
    reg_addr_t             stage_rd    [result_stages];
    logic [data_width-1:0] stage_data  [result_stages];

    //////////////////////////////
    // EX stage
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ex_valid <= 1'b0;
        else
            ex_valid <= issue_valid;
    end

    always_ff @(posedge clk)
    begin
        ex_op  <= issue_op;
        ex_rs1 <= issue_rs1;
        ex_rs2 <= issue_rs2;
        ex_rd  <= issue_rd;
        ex_imm <= issue_imm;
    end

    //////////////////////////////
    // DM1 through WB
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < result_stages; i++)
                stage_valid[i] <= 1'b0;
        end
        else
        begin
            stage_valid[0] <= ex_valid;
            for (int i = 1; i < result_stages; i++)
                stage_valid[i] <= stage_valid[i-1];
        end
    end

    // Result and destination shift along with the valid bits
    always_ff @(posedge clk)
    begin
        stage_rd[0]   <= ex_rd;
        // Results for x0 travel as zero
        stage_data[0] <= (ex_rd == '0) ? '0 : alu_result;
        for (int i = 1; i < result_stages; i++)
        begin
            stage_rd[i]   <= stage_rd[i-1];
            stage_data[i] <= stage_data[i-1];
        end
    end

    assign dm1_valid = stage_valid[0];
    assign dm1_rd    = stage_rd[0];
    assign dm1_data  = stage_data[0];
    assign dm2_valid = stage_valid[1];
    assign dm2_rd    = stage_rd[1];
    assign dm2_data  = stage_data[1];
    assign dm3_valid = stage_valid[2];
    assign dm3_rd    = stage_rd[2];
    assign dm3_data  = stage_data[2];
    assign wb_valid  = stage_valid[3];
    assign wb_rd     = stage_rd[3];
    assign wb_data   = stage_data[3];

endmodule

//--- exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    input  alu_op_t               issue_op,
    input  reg_addr_t             issue_rs1,
    input  reg_addr_t             issue_rs2,
    input  reg_addr_t             issue_rd,
    input  logic [data_width-1:0] issue_imm,
    output logic                  wb_valid,
    output reg_addr_t             wb_rd,
    output logic [data_width-1:0] wb_data,
    output fwd_src_t              rs1_src,
    output fwd_src_t              rs2_src
);

    // EX fields
    logic                  ex_valid;
    alu_op_t               ex_op;
    reg_addr_t             ex_rs1;
    reg_addr_t             ex_rs2;
    reg_addr_t             ex_rd;
    logic [data_width-1:0] ex_imm;

    // Later stages
    logic                  dm1_valid;
    reg_addr_t             dm1_rd;
    logic [data_width-1:0] dm1_data;
    logic                  dm2_valid;
    reg_addr_t             dm2_rd;
    logic [data_width-1:0] dm2_data;
    logic                  dm3_valid;
    reg_addr_t             dm3_rd;
    logic [data_width-1:0] dm3_data;

    // Operands and result
    logic [data_width-1:0] rf_rs1_data;
    logic [data_width-1:0] rf_rs2_data;
    logic [data_width-1:0] rs1_data;
    logic [data_width-1:0] rs2_data;
    logic [data_width-1:0] alu_result;

    reg_file #(
        .data_width(data_width)
    ) i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (ex_rs1),
        .rs2_addr (ex_rs2),
        .wr_en    (wb_valid),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    forwarding_unit #(
        .data_width(data_width)
    ) i_forwarding_unit (
        .rs1_addr    (ex_rs1),
        .rs2_addr    (ex_rs2),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .dm1_valid   (dm1_valid),
        .dm1_rd      (dm1_rd),
        .dm1_data    (dm1_data),
        .dm2_valid   (dm2_valid),
        .dm2_rd      (dm2_rd),
        .dm2_data    (dm2_data),
        .dm3_valid   (dm3_valid),
        .dm3_rd      (dm3_rd),
        .dm3_data    (dm3_data),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_src     (rs1_src),
        .rs2_src     (rs2_src)
    );

    alu #(
        .data_width(data_width)
    ) i_alu (
        .op     (ex_op),
        .a      (rs1_data),
        .b      (rs2_data),
        .imm    (ex_imm),
        .result (alu_result)
    );

    result_pipe #(
        .data_width(data_width)
    ) i_result_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_rd    (issue_rd),
        .issue_imm   (issue_imm),
        .alu_result  (alu_result),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_rd       (ex_rd),
        .ex_imm      (ex_imm),
        .dm1_valid   (dm1_valid),
        .dm1_rd      (dm1_rd),
        .dm1_data    (dm1_data),
        .dm2_valid   (dm2_valid),
        .dm2_rd      (dm2_rd),
        .dm2_data    (dm2_data),
        .dm3_valid   (dm3_valid),
        .dm3_rd      (dm3_rd),
        .dm3_data    (dm3_data),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

endmodule

//--- tb_exu_top.sv
`timescale 1ns/1ps

module tb_exu_top import exu_pkg::*;;

    localparam int data_width       = 32;
    localparam int reset_cycles     = 8;
    localparam int directed_slots   = 62;
    localparam int random_instrs    = 300;
    localparam int random_slots_max = 2 * random_instrs;
    localparam int drain_slots      = 8;
    localparam int cycle_limit      = reset_cycles + directed_slots + random_slots_max
                                      + drain_slots + 20;

    logic                  clk;
    logic                  rst_n;
    logic                  issue_valid;
    alu_op_t               issue_op;
    reg_addr_t             issue_rs1;
    reg_addr_t             issue_rs2;
    reg_addr_t             issue_rd;
    logic [data_width-1:0] issue_imm;
    logic                  wb_valid;
    reg_addr_t             wb_rd;
    logic [data_width-1:0] wb_data;
    fwd_src_t              rs1_src;
    fwd_src_t              rs2_src;

    // Program-order reference state
    logic [data_width-1:0] arch [num_regs];
    reg_addr_t             exp_rd_q [$];
    logic [data_width-1:0] exp_data_q [$];

    // Issue history where index 1 is the slot in DM1 once the new slot reaches EX
    logic                  hist_valid [1:4];
    reg_addr_t             hist_rd    [1:4];

    // Expected forwarding choice of the slot just driven and of the slot in EX
    logic                  next_ex_valid;
    fwd_src_t              next_rs1_src;
    fwd_src_t              next_rs2_src;
    logic                  chk_ex_valid;
    fwd_src_t              chk_rs1_src;
    fwd_src_t              chk_rs2_src;

    reg_addr_t             reg_set [8];
    int                    src_seen [5];
    int                    errors;
    int                    checks;
    int                    cycle_count;

    exu_top #(
        .data_width(data_width)
    ) i_exu_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_rd    (issue_rd),
        .issue_imm   (issue_imm),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .rs1_src     (rs1_src),
        .rs2_src     (rs2_src)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [data_width-1:0] expected_result(input alu_op_t op,
                                                              input logic [data_width-1:0] a,
                                                              input logic [data_width-1:0] b,
                                                              input logic [data_width-1:0] imm);
        logic [data_width-1:0] res;
        logic                  lt;
        lt = ($signed(a) < $signed(b));
        case (op)
            alu_add:  res = a + b;
            alu_sub:  res = a - b;
            alu_and:  res = a & b;
            alu_or:   res = a | b;
            alu_xor:  res = a ^ b;
            alu_slt:  res = {{(data_width-1){1'b0}}, lt};
            alu_sll:  res = a << b[4:0];
            alu_srl:  res = a >> b[4:0];
            alu_addi: res = a + imm;
            default:  res = '0;
        endcase
        return res;
    endfunction

    // Oldest stage first so that a younger match overrides it
    function automatic fwd_src_t expected_source(input reg_addr_t addr);
        fwd_src_t src;
        src = fwd_none;
        if (addr != 5'd0)
        begin
            if (hist_valid[4] && (hist_rd[4] == addr))
                src = fwd_wb;
            if (hist_valid[3] && (hist_rd[3] == addr))
                src = fwd_dm3;
            if (hist_valid[2] && (hist_rd[2] == addr))
                src = fwd_dm2;
            if (hist_valid[1] && (hist_rd[1] == addr))
                src = fwd_dm1;
        end
        return src;
    endfunction

    function automatic reg_addr_t pick_reg();
        logic [2:0] idx;
        idx = 3'($urandom_range(7, 0));
        return reg_set[idx];
    endfunction

    function automatic alu_op_t random_op();
        logic [3:0] sel;
        alu_op_t    op;
        sel = 4'($urandom_range(8, 0));
        case (sel)
            4'd1:    op = alu_sub;
            4'd2:    op = alu_and;
            4'd3:    op = alu_or;
            4'd4:    op = alu_xor;
            4'd5:    op = alu_slt;
            4'd6:    op = alu_sll;
            4'd7:    op = alu_srl;
            4'd8:    op = alu_addi;
            default: op = alu_add;
        endcase
        return op;
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // One issue slot per cycle with the model updated in program order
    task automatic issue_slot(input logic valid, input alu_op_t op, input reg_addr_t rs1,
                              input reg_addr_t rs2, input reg_addr_t rd,
                              input logic [data_width-1:0] imm);
        logic [data_width-1:0] res;
        @(posedge clk);
        #1;
        issue_valid   = valid;
        issue_op      = op;
        issue_rs1     = rs1;
        issue_rs2     = rs2;
        issue_rd      = rd;
        issue_imm     = imm;
        next_ex_valid = valid;
        if (valid)
        begin
            next_rs1_src = expected_source(rs1);
            next_rs2_src = expected_source(rs2);
            res = expected_result(op, arch[rs1], arch[rs2], imm);
            if (rd == 5'd0)
                res = '0;
            else
                arch[rd] = res;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
        end
        hist_valid[4] = hist_valid[3];
        hist_rd[4]    = hist_rd[3];
        hist_valid[3] = hist_valid[2];
        hist_rd[3]    = hist_rd[2];
        hist_valid[2] = hist_valid[1];
        hist_rd[2]    = hist_rd[1];
        hist_valid[1] = valid;
        hist_rd[1]    = rd;
    endtask

    task automatic issue_instr(input alu_op_t op, input reg_addr_t rs1, input reg_addr_t rs2,
                               input reg_addr_t rd, input logic [data_width-1:0] imm);
        issue_slot(1'b1, op, rs1, rs2, rd, imm);
    endtask

    // Invalid slot that still carries a register address
    task automatic issue_bubble(input reg_addr_t rd);
        issue_slot(1'b0, alu_add, rd, rd, rd, '0);
    endtask

    task automatic chain_test();
        issue_instr(alu_addi, 5'd0, 5'd0, 5'd1, 32'd5);
        issue_instr(alu_addi, 5'd1, 5'd0, 5'd1, 32'd3);
        issue_instr(alu_add,  5'd1, 5'd1, 5'd2, '0);
        issue_instr(alu_add,  5'd2, 5'd1, 5'd3, '0);
        issue_instr(alu_addi, 5'd3, 5'd0, 5'd4, 32'hFFFF_FFF9);
        issue_instr(alu_sub,  5'd4, 5'd3, 5'd5, '0);
    endtask

    // Consumer at 2, 3, 4 and 5 cycles behind its producer
    task automatic distance_test();
        for (int d = 2; d <= 5; d++)
        begin
            issue_instr(alu_addi, 5'd0, 5'd0, 5'd6, d * 32'h111);
            repeat (d - 1) issue_bubble(5'd6);
            issue_instr(alu_add, 5'd6, 5'd0, 5'd7, '0);
            repeat (4) issue_bubble(5'd7);
        end
    endtask

    task automatic same_rd_test();
        issue_instr(alu_addi, 5'd0, 5'd0, 5'd8, 32'd1);
        issue_instr(alu_addi, 5'd0, 5'd0, 5'd8, 32'd2);
        issue_instr(alu_addi, 5'd0, 5'd0, 5'd8, 32'd3);
        issue_instr(alu_addi, 5'd0, 5'd0, 5'd8, 32'd4);
        issue_instr(alu_add,  5'd8, 5'd8, 5'd9, '0);
        issue_instr(alu_addi, 5'd0, 5'd0, 5'd10, 32'h55);
        issue_instr(alu_addi, 5'd0, 5'd0, 5'd10, 32'h66);
        issue_bubble(5'd10);
        issue_bubble(5'd10);
        issue_instr(alu_or,   5'd10, 5'd10, 5'd11, '0);
    endtask

    task automatic x0_test();
        issue_instr(alu_addi, 5'd0, 5'd0, 5'd0, 32'h123);
        issue_instr(alu_add,  5'd0, 5'd0, 5'd12, '0);
        issue_instr(alu_addi, 5'd0, 5'd0, 5'd13, 32'h77);
        issue_instr(alu_sub,  5'd13, 5'd13, 5'd0, '0);
        issue_instr(alu_add,  5'd0, 5'd13, 5'd14, '0);
    endtask

    // Stale bubbles fill every later stage with a matching rd
    task automatic stale_bubble_test();
        issue_instr(alu_addi, 5'd0, 5'd0, 5'd16, 32'h5A5A);
        repeat (4) issue_bubble(5'd16);
        issue_instr(alu_add, 5'd16, 5'd0, 5'd17, '0);
        issue_instr(alu_add, 5'd16, 5'd16, 5'd18, '0);
    endtask

    task automatic random_test();
        for (int i = 0; i < random_instrs; i++)
        begin
            if ($urandom_range(3, 0) == 0)
                issue_bubble(pick_reg());
            issue_instr(random_op(), pick_reg(), pick_reg(), pick_reg(), $urandom());
        end
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////

    always @(posedge clk)
    begin
        if (!rst_n)
            chk_ex_valid <= 1'b0;
        else
            chk_ex_valid <= next_ex_valid;
        chk_rs1_src <= next_rs1_src;
        chk_rs2_src <= next_rs2_src;
    end

    task automatic check_writeback();
        reg_addr_t             exp_rd;
        logic [data_width-1:0] exp_data;
        checks++;
        assert (exp_rd_q.size() != 0)
        else
        begin
            errors++;
            $display("wb_valid is high while no instruction is expected at write-back");
        end
        if (exp_rd_q.size() != 0)
        begin
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            checks += 2;
            assert (wb_rd == exp_rd)
            else
            begin
                errors++;
                $display("Mismatch wb_rd: expected %h, actual %h", exp_rd, wb_rd);
            end
            assert (wb_data == exp_data)
            else
            begin
                errors++;
                $display("Mismatch wb_data: expected %h, actual %h", exp_data, wb_data);
            end
        end
    endtask

    task automatic check_sources();
        checks += 2;
        src_seen[int'(rs1_src)]++;
        src_seen[int'(rs2_src)]++;
        assert (rs1_src == chk_rs1_src)
        else
        begin
            errors++;
            $display("Mismatch rs1_src: expected %h, actual %h", chk_rs1_src, rs1_src);
        end
        assert (rs2_src == chk_rs2_src)
        else
        begin
            errors++;
            $display("Mismatch rs2_src: expected %h, actual %h", chk_rs2_src, rs2_src);
        end
    endtask

    // DUT outputs are settled mid-cycle
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (wb_valid)
                check_writeback();
            if (chk_ex_valid)
                check_sources();
        end
    end

    initial
    begin
        void'($urandom(32'h287e28d1));
        reg_set       = '{5'd0, 5'd1, 5'd2, 5'd3, 5'd5, 5'd8, 5'd13, 5'd31};
        errors        = 0;
        checks        = 0;
        cycle_count   = 0;
        rst_n         = 1'b0;
        issue_valid   = 1'b0;
        issue_op      = alu_add;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_rd      = '0;
        issue_imm     = '0;
        next_ex_valid = 1'b0;
        next_rs1_src  = fwd_none;
        next_rs2_src  = fwd_none;
        for (int i = 0; i < num_regs; i++)
            arch[i] = '0;
        for (int s = 0; s < 5; s++)
            src_seen[s] = 0;
        hist_valid = '{1'b0, 1'b0, 1'b0, 1'b0};
        hist_rd    = '{5'd0, 5'd0, 5'd0, 5'd0};

        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;

        chain_test();
        distance_test();
        same_rd_test();
        x0_test();
        stale_bubble_test();
        random_test();
        repeat (drain_slots) issue_bubble(5'd0);
        @(negedge clk);

        assert (exp_rd_q.size() == 0)
        else
        begin
            errors++;
            $display("%0d instructions never reached write-back", exp_rd_q.size());
        end
        for (int s = 0; s < 5; s++)
        begin
            assert (src_seen[s] > 0)
            else
            begin
                errors++;
                $display("Forwarding source %0d was never selected", s);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- filelist.f
exu_pkg.sv
reg_file.sv
forwarding_unit.sv
alu.sv
result_pipe.sv
exu_top.sv
tb_exu_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_exu_top -f filelist.f -o sim_exu
./obj_dir/sim_exu | tee sim.log

if grep -qF "*** PASSED ***" sim.log
then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1
